// ==== Bender.yml ====
package:
  name: ft245_bridge

sources:
  - include_dirs:
      - hw
    files:
      - hw/ft245_pkg.sv
      - hw/afifo.sv
      - hw/ft245_sync_engine.sv
      - hw/ft245_apb_regs.sv
      - hw/ft245_bridge_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/ft245_chip_model.sv
      - tb/ft245_tb.sv

// ==== flist.f ====
+incdir+hw
hw/ft245_pkg.sv
hw/afifo.sv
hw/ft245_sync_engine.sv
hw/ft245_apb_regs.sv
hw/ft245_bridge_top.sv
tb/ft245_chip_model.sv
tb/ft245_tb.sv

// ==== hw/afifo.sv ====
// async fifo: dual-clock first-word-fall-through buffer with gray-coded pointers
`timescale 1ns/10ps
`default_nettype none

module afifo #(
	parameter int data_width = 8,
	parameter int addr_width = 4
) (
	input  logic                  rst,
	input  logic                  din_clk,
	input  logic                  dout_clk,
	input  logic                  wr_en,
	input  logic                  rd_en,
	input  logic [data_width-1:0] data_in,
	output logic [data_width-1:0] data_out,
	output logic                  full,
	output logic                  empty
);

	localparam int depth = 1 << addr_width;

	logic [data_width-1:0] mem [depth];

	// pointers carry one extra bit to tell full from empty
	logic [addr_width:0] wr_bin;
	logic [addr_width:0] wr_bin_next;
	logic [addr_width:0] wr_gray;
	logic [addr_width:0] wr_gray_next;
	logic [addr_width:0] rd_bin;
	logic [addr_width:0] rd_bin_next;
	logic [addr_width:0] rd_gray;
	logic [addr_width:0] rd_gray_next;

	// cross-domain copies
	logic [addr_width:0] rd_gray_s1;
	logic [addr_width:0] rd_gray_s2;
	logic [addr_width:0] wr_gray_s1;
	logic [addr_width:0] wr_gray_s2;

	logic wr_push;
	logic rd_pop;

	assign wr_push = wr_en & ~full;
	assign rd_pop = rd_en & ~empty;

	assign wr_bin_next = wr_bin + {{addr_width{1'b0}}, wr_push};
	assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;
	assign rd_bin_next = rd_bin + {{addr_width{1'b0}}, rd_pop};
	assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

	// write side
	always_ff @(posedge din_clk) begin
		if (wr_push) begin
			mem[wr_bin[addr_width-1:0]] <= data_in;
		end
	end

	always_ff @(posedge din_clk) begin
		if (rst) begin
			wr_bin <= '0;
			wr_gray <= '0;
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
			full <= 1'b0;
		end else begin
			wr_bin <= wr_bin_next;
			wr_gray <= wr_gray_next;
			rd_gray_s1 <= rd_gray;
			rd_gray_s2 <= rd_gray_s1;
			// full when the write pointer laps the read pointer
			full <= (wr_gray_next == {~rd_gray_s2[addr_width:addr_width-1],
				rd_gray_s2[addr_width-2:0]});
		end
	end

	// read side, head word shown without a read cycle
	assign data_out = mem[rd_bin[addr_width-1:0]];

	always_ff @(posedge dout_clk) begin
		if (rst) begin
			rd_bin <= '0;
			rd_gray <= '0;
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
			empty <= 1'b1;
		end else begin
			rd_bin <= rd_bin_next;
			rd_gray <= rd_gray_next;
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
			empty <= (rd_gray_next == wr_gray_s2);
		end
	end

endmodule

`default_nettype wire

// ==== hw/ft245_apb_regs.sv ====
// ft245 apb registers: DATA and STATUS access to the inbound and outbound fifos
`timescale 1ns/10ps
`default_nettype none

`include "ft245_defines.svh"

module ft245_apb_regs (
	input  logic                  clk,
	input  logic                  rst,
	input  ft245_pkg::apb_req_t   req,
	input  logic                  in_empty,
	input  logic                  out_full,
	input  logic [`FT_DATA_W-1:0] in_data,
	output ft245_pkg::apb_rsp_t   rsp,
	output logic                  in_rd,
	output logic                  out_wr,
	output logic [`FT_DATA_W-1:0] out_data
);

	logic [31:0] prdata;
	logic        pslverr;
	logic        setup;
	logic        access;
	logic        is_data;
	logic        is_status;

	assign setup = req.psel & ~req.penable;
	assign access = req.psel & req.penable;
	assign is_data = (req.paddr == `FT_REG_DATA);
	assign is_status = (req.paddr == `FT_REG_STATUS);

	// response is decided in the setup phase and held after the transfer.
	// only this block pops inbound and pushes outbound, so the flags it
	// sampled cannot turn against it before the access edge
	always_ff @(posedge clk) begin
		if (rst) begin
			prdata <= '0;
			pslverr <= 1'b0;
		end else if (setup) begin
			prdata <= '0;
			pslverr <= 1'b0;
			if (is_data && !req.pwrite) begin
				if (in_empty) begin
					pslverr <= 1'b1;
				end else begin
					prdata <= {{(32 - `FT_DATA_W){1'b0}}, in_data};
				end
			end else if (is_data && req.pwrite) begin
				// outbound full drops the byte
				pslverr <= out_full;
			end else if (is_status && !req.pwrite) begin
				prdata <= {30'b0, out_full, ~in_empty};
			end else begin
				pslverr <= 1'b1;
			end
		end
	end

	// strobes fire on the access edge of a good transfer
	assign in_rd = access & is_data & ~req.pwrite & ~pslverr;
	assign out_wr = access & is_data & req.pwrite & ~pslverr;
	assign out_data = req.pwdata[`FT_DATA_W-1:0];

	// no wait states
	assign rsp = '{
		prdata: prdata,
		pready: 1'b1,
		pslverr: pslverr
	};

endmodule

`default_nettype wire

// ==== hw/ft245_bridge_top.sv ====
// ft245 bridge top: apb registers, two async fifos and the chip engine
`timescale 1ns/10ps
`default_nettype none

`include "ft245_defines.svh"

module ft245_bridge_top (
	input  logic                  clk,
	input  logic                  ftdi_clk,
	input  logic                  rst,
	input  ft245_pkg::apb_req_t   apb_req,
	input  ft245_pkg::ft_status_t ftdi_status,
	output ft245_pkg::apb_rsp_t   apb_rsp,
	output ft245_pkg::ft_ctrl_t   ftdi_ctrl,
	inout  wire [`FT_DATA_W-1:0]  ftdi_data
);

	ft245_pkg::ft_byte_t in_head;
	ft245_pkg::ft_byte_t out_head;
	ft245_pkg::ft_byte_t out_wdata;

	logic in_rd;
	logic in_wr;
	logic in_empty;
	logic in_full;
	logic out_rd;
	logic out_wr;
	logic out_empty;
	logic out_full;

	// host drives the bus only while the chip output is off
	assign ftdi_data = ftdi_ctrl.oe_n ? out_head : {`FT_DATA_W{1'bz}};

	ft245_apb_regs regs (
		.clk      (clk),
		.rst      (rst),
		.req      (apb_req),
		.in_empty (in_empty),
		.out_full (out_full),
		.in_data  (in_head),
		.rsp      (apb_rsp),
		.in_rd    (in_rd),
		.out_wr   (out_wr),
		.out_data (out_wdata)
	);

	// chip to host
	afifo #(.data_width(`FT_DATA_W), .addr_width(`FT_FIFO_AW)) fifo_in (
		.rst      (rst),
		.din_clk  (ftdi_clk),
		.dout_clk (clk),
		.wr_en    (in_wr),
		.rd_en    (in_rd),
		.data_in  (ftdi_data),
		.data_out (in_head),
		.full     (in_full),
		.empty    (in_empty)
	);

	// host to chip
	afifo #(.data_width(`FT_DATA_W), .addr_width(`FT_FIFO_AW)) fifo_out (
		.rst      (rst),
		.din_clk  (clk),
		.dout_clk (ftdi_clk),
		.wr_en    (out_wr),
		.rd_en    (out_rd),
		.data_in  (out_wdata),
		.data_out (out_head),
		.full     (out_full),
		.empty    (out_empty)
	);

	ft245_sync_engine engine (
		.ftdi_clk  (ftdi_clk),
		.rst       (rst),
		.status    (ftdi_status),
		.in_full   (in_full),
		.out_empty (out_empty),
		.ctrl      (ftdi_ctrl),
		.in_wr     (in_wr),
		.out_rd    (out_rd)
	);

endmodule

`default_nettype wire

// ==== hw/ft245_defines.svh ====
// ft245 bridge parameters: chip bus width, fifo depth and apb register map
`ifndef FT245_DEFINES_SVH
`define FT245_DEFINES_SVH

// one byte per transfer on the chip bus
`define FT_DATA_W 8

// 512 entries per direction
`define FT_FIFO_AW 9

// apb address width and register offsets
`define FT_APB_AW 4

`define FT_REG_DATA 4'h0

`define FT_REG_STATUS 4'h4

`endif

// ==== hw/ft245_pkg.sv ====
// ft245 bridge types: engine states, apb request and response, chip pin groups
`default_nettype none

`include "ft245_defines.svh"

package ft245_pkg;

	typedef logic [`FT_DATA_W-1:0] ft_byte_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ_OE,
		ST_READ,
		ST_WRITE
	} ft_state_e;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [`FT_APB_AW-1:0] paddr;
		logic [31:0]           pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// chip flags, both active low
	typedef struct packed {
		logic rde_n;
		logic txe_n;
	} ft_status_t;

	typedef struct packed {
		logic rd_n;
		logic oe_n;
		logic wr_n;
	} ft_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/ft245_sync_engine.sv ====
// ft245 sync engine: runs the chip read and write handshake on ftdi_clk
`timescale 1ns/10ps
`default_nettype none

module ft245_sync_engine (
	input  logic                  ftdi_clk,
	input  logic                  rst,
	input  ft245_pkg::ft_status_t status,
	input  logic                  in_full,
	input  logic                  out_empty,
	output ft245_pkg::ft_ctrl_t   ctrl,
	output logic                  in_wr,
	output logic                  out_rd
);

	ft245_pkg::ft_state_e state;

	logic rd_n;
	logic oe_n;
	logic rd_go;
	logic wr_go;
	logic wr_active;

	// chip has data and there is room for it
	assign rd_go = ~status.rde_n & ~in_full;

	// writes only when no read is waiting
	assign wr_go = ~rd_go & ~status.txe_n & ~out_empty;

	// wr_n follows the fifo head directly
	assign wr_active = (state == ft245_pkg::ST_WRITE) & ~out_empty;

	// capture the bus byte on the same edge the chip hands it over
	assign in_wr = (state == ft245_pkg::ST_READ) & ~rd_n & ~status.rde_n & ~in_full;

	// pop only when the chip takes the byte
	assign out_rd = wr_active & ~status.txe_n;

	assign ctrl = '{
		rd_n: rd_n,
		oe_n: oe_n,
		wr_n: ~wr_active
	};

	always_ff @(posedge ftdi_clk) begin
		if (rst) begin
			state <= ft245_pkg::ST_IDLE;
			rd_n <= 1'b1;
			oe_n <= 1'b1;
		end else begin
			case (state)
				ft245_pkg::ST_IDLE: begin
					if (rd_go) begin
						// turn the bus around first
						oe_n <= 1'b0;
						state <= ft245_pkg::ST_READ_OE;
					end else if (wr_go) begin
						state <= ft245_pkg::ST_WRITE;
					end
				end
				ft245_pkg::ST_READ_OE: begin
					// rd_n one cycle behind oe_n
					rd_n <= 1'b0;
					state <= ft245_pkg::ST_READ;
				end
				ft245_pkg::ST_READ: begin
					if (status.rde_n | in_full) begin
						rd_n <= 1'b1;
						oe_n <= 1'b1;
						state <= ft245_pkg::ST_IDLE;
					end
				end
				ft245_pkg::ST_WRITE: begin
					// refused byte stays at the fifo head
					if (status.txe_n | out_empty) begin
						state <= ft245_pkg::ST_IDLE;
					end
				end
				default: begin
					rd_n <= 1'b1;
					oe_n <= 1'b1;
					state <= ft245_pkg::ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tb/ft245_chip_model.sv ====
// ft245 chip model: sync fifo chip with receive and transmit byte queues and txe back-pressure
`timescale 1ns/10ps
`default_nettype none

`include "ft245_defines.svh"

module ft245_chip_model (
	input  logic                  ftdi_clk,
	input  logic                  rst,
	input  ft245_pkg::ft_ctrl_t   ctrl,
	output ft245_pkg::ft_status_t status,
	inout  wire [`FT_DATA_W-1:0]  data
);

	ft245_pkg::ft_byte_t rx_q[$];
	ft245_pkg::ft_byte_t tx_q[$];
	ft245_pkg::ft_byte_t rx_head;
	logic                rde_n;
	logic                txe_n;
	logic                txe_hold;
	logic                txe_rand;
	integer              seed;
	integer              r;

	initial begin
		rde_n = 1'b1;
		txe_n = 1'b1;
		rx_head = '0;
		txe_hold = 1'b0;
		txe_rand = 1'b0;
		seed = 50627;
	end

	assign status = '{rde_n: rde_n, txe_n: txe_n};

	// chip owns the bus while output enable is low
	assign data = ctrl.oe_n ? {`FT_DATA_W{1'bz}} : rx_head;

	always @(posedge ftdi_clk) begin
		if (!rst) begin
			// host takes the head byte on this edge
			if (!ctrl.rd_n && !ctrl.oe_n && !rde_n) begin
				void'(rx_q.pop_front());
			end
			if (!ctrl.wr_n && !txe_n) begin
				tx_q.push_back(data);
			end
		end
		#2;
		if (rst) begin
			rde_n = 1'b1;
			txe_n = 1'b1;
		end else begin
			rde_n = (rx_q.size() == 0);
			if (rx_q.size() != 0) begin
				rx_head = rx_q[0];
			end
			if (txe_hold) begin
				txe_n = 1'b1;
			end else if (txe_rand) begin
				r = $random(seed);
				txe_n = r[0];
			end else begin
				txe_n = 1'b0;
			end
		end
	end

	function automatic int tx_count();
		return tx_q.size();
	endfunction

	function automatic ft245_pkg::ft_byte_t tx_byte(input int n);
		return tx_q[n];
	endfunction

	task automatic load_rx(input ft245_pkg::ft_byte_t b);
		rx_q.push_back(b);
	endtask

	// hold keeps txe_n high, rnd toggles it at random
	task automatic set_txe(input logic hold, input logic rnd);
		txe_hold = hold;
		txe_rand = rnd;
	endtask

endmodule

`default_nettype wire

// ==== tb/ft245_tb.sv ====
// ft245 bridge testbench: apb host, chip model and stream checks in both directions
`timescale 1ns/10ps
`default_nettype none

`include "ft245_defines.svh"

module ft245_tb;

	localparam int cycle_limit = 20000;

	logic                  clk;
	logic                  ftdi_clk;
	logic                  rst;
	ft245_pkg::apb_req_t   apb_req;
	ft245_pkg::apb_rsp_t   apb_rsp;
	ft245_pkg::ft_status_t ftdi_status;
	ft245_pkg::ft_ctrl_t   ftdi_ctrl;
	wire [`FT_DATA_W-1:0]  ftdi_data;

	// issued bytes per direction, with the host write result
	ft245_pkg::ft_byte_t h2c_bytes[$];
	logic                h2c_refused[$];
	ft245_pkg::ft_byte_t c2h_bytes[$];
	ft245_pkg::apb_rsp_t c2h_got[$];
	int                  h2c_expected;
	int                  h2c_checked;
	int                  c2h_checked;
	int                  cycles;
	integer              seed;

	ft245_bridge_top dut (
		.clk         (clk),
		.ftdi_clk    (ftdi_clk),
		.rst         (rst),
		.apb_req     (apb_req),
		.ftdi_status (ftdi_status),
		.apb_rsp     (apb_rsp),
		.ftdi_ctrl   (ftdi_ctrl),
		.ftdi_data   (ftdi_data)
	);

	ft245_chip_model chip (
		.ftdi_clk (ftdi_clk),
		.rst      (rst),
		.ctrl     (ftdi_ctrl),
		.status   (ftdi_status),
		.data     (ftdi_data)
	);

	always #10 clk = ~clk;

	// about 60 MHz, unrelated to clk
	always #8.33 ftdi_clk = ~ftdi_clk;

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic compare_byte(input ft245_pkg::ft_byte_t got, input ft245_pkg::ft_byte_t exp,
		input int n);
		if (got !== exp) begin
			abort_run($sformatf("** Error at %0t: chip byte %0d is %h, expected %h",
				$time, n, got, exp));
		end
	endtask

	task automatic compare_rsp(input ft245_pkg::apb_rsp_t got, input ft245_pkg::apb_rsp_t exp,
		input string what);
		if (got.pslverr !== exp.pslverr || got.pready !== exp.pready ||
			got.prdata !== exp.prdata) begin
			abort_run($sformatf(
				"** Error at %0t: %s gave pslverr %b pready %b prdata %h, expected %b %b %h",
				$time, what, got.pslverr, got.pready, got.prdata,
				exp.pslverr, exp.pready, exp.prdata));
		end
	endtask

	task automatic compare_ctrl(input ft245_pkg::ft_ctrl_t got, input ft245_pkg::ft_ctrl_t exp,
		input string what);
		if (got !== exp) begin
			abort_run($sformatf("** Error at %0t: %s strobes are %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// n-th byte each side should see, refused host writes skipped
	function automatic ft245_pkg::ft_byte_t expected_byte(input logic to_host, input int n);
		int k;
		int seen;
		expected_byte = '0;
		seen = 0;
		if (to_host) begin
			expected_byte = c2h_bytes[n];
		end else begin
			for (k = 0; k < h2c_bytes.size(); k++) begin
				if (!h2c_refused[k]) begin
					if (seen == n) begin
						expected_byte = h2c_bytes[k];
					end
					seen++;
				end
			end
		end
	endfunction

	// compare process, checks every byte as it shows up
	always @(posedge clk) begin
		ft245_pkg::apb_rsp_t exp;
		while (h2c_checked < chip.tx_count()) begin
			if (h2c_checked >= h2c_expected) begin
				abort_run("chip received more bytes than the host wrote");
			end
			compare_byte(chip.tx_byte(h2c_checked), expected_byte(1'b0, h2c_checked), h2c_checked);
			h2c_checked++;
		end
		while (c2h_checked < c2h_got.size()) begin
			if (c2h_checked >= c2h_bytes.size()) begin
				abort_run("host read more bytes than the chip sent");
			end
			exp = '{prdata: {{(32 - `FT_DATA_W){1'b0}}, expected_byte(1'b1, c2h_checked)},
				pready: 1'b1, pslverr: 1'b0};
			compare_rsp(c2h_got[c2h_checked], exp, "data read");
			c2h_checked++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			abort_run("timeout: the run did not finish within the cycle limit");
		end
	end

	// setup phase, access phase, then back to idle
	task automatic apb_xfer(input logic write, input logic [`FT_APB_AW-1:0] addr,
		input logic [31:0] wdata, output ft245_pkg::apb_rsp_t rsp);
		@(posedge clk);
		#2;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge clk);
		#2;
		apb_req.penable = 1'b1;
		@(posedge clk);
		#2;
		rsp = apb_rsp;
		apb_req = '0;
	endtask

	task automatic write_byte(input ft245_pkg::ft_byte_t b, output ft245_pkg::apb_rsp_t rsp);
		apb_xfer(1'b1, `FT_REG_DATA, {{(32 - `FT_DATA_W){1'b0}}, b}, rsp);
		h2c_bytes.push_back(b);
		h2c_refused.push_back(rsp.pslverr);
		if (!rsp.pslverr) begin
			h2c_expected++;
		end
	endtask

	task automatic read_when_ready();
		ft245_pkg::apb_rsp_t rsp;
		rsp = '0;
		while (rsp.prdata[0] !== 1'b1) begin
			apb_xfer(1'b0, `FT_REG_STATUS, 32'h0, rsp);
		end
		apb_xfer(1'b0, `FT_REG_DATA, 32'h0, rsp);
		c2h_got.push_back(rsp);
	endtask

	task automatic load_rx(input ft245_pkg::ft_byte_t b);
		c2h_bytes.push_back(b);
		chip.load_rx(b);
	endtask

	// extra cycles let a stray byte show up
	task automatic wait_drained();
		while (h2c_checked < h2c_expected || c2h_checked < c2h_bytes.size()) begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk);
	endtask

	initial begin
		ft245_pkg::apb_rsp_t rsp;
		integer r;
		int i;
		int wr_cnt;
		int rd_cnt;
		clk = 1'b0;
		ftdi_clk = 1'b0;
		rst = 1'b1;
		apb_req = '0;
		seed = 50627;
		h2c_expected = 0;
		h2c_checked = 0;
		c2h_checked = 0;
		cycles = 0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		repeat (4) @(posedge clk);

		// reset state
		compare_ctrl(ftdi_ctrl, '{rd_n: 1'b1, oe_n: 1'b1, wr_n: 1'b1}, "after reset");
		apb_xfer(1'b0, `FT_REG_STATUS, 32'h0, rsp);
		compare_rsp(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b0}, "status after reset");
		apb_xfer(1'b0, `FT_REG_DATA, 32'h0, rsp);
		compare_rsp(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b1}, "read of empty fifo");

		// host to chip
		for (i = 0; i < 64; i++) begin
			r = $random(seed);
			write_byte(r[7:0], rsp);
		end
		wait_drained();

		// chip to host
		for (i = 0; i < 64; i++) begin
			r = $random(seed);
			load_rx(r[7:0]);
		end
		for (i = 0; i < 64; i++) begin
			read_when_ready();
		end
		wait_drained();

		// fill outbound while the chip refuses
		chip.set_txe(1'b1, 1'b0);
		for (i = 0; i < 512; i++) begin
			r = $random(seed);
			write_byte(r[7:0], rsp);
			compare_rsp(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b0}, "write to fifo");
		end
		apb_xfer(1'b0, `FT_REG_STATUS, 32'h0, rsp);
		compare_rsp(rsp, '{prdata: 32'h2, pready: 1'b1, pslverr: 1'b0}, "status when full");
		r = $random(seed);
		write_byte(r[7:0], rsp);
		compare_rsp(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b1}, "write to full fifo");
		chip.set_txe(1'b0, 1'b0);
		wait_drained();

		// random txe back-pressure
		chip.set_txe(1'b0, 1'b1);
		for (i = 0; i < 200; i++) begin
			r = $random(seed);
			write_byte(r[7:0], rsp);
		end
		wait_drained();

		// both directions interleaved
		for (i = 0; i < 100; i++) begin
			r = $random(seed);
			load_rx(r[7:0]);
		end
		wr_cnt = 0;
		rd_cnt = 0;
		while (wr_cnt < 100 || rd_cnt < 100) begin
			if (wr_cnt < 100) begin
				r = $random(seed);
				write_byte(r[7:0], rsp);
				wr_cnt++;
			end
			apb_xfer(1'b0, `FT_REG_STATUS, 32'h0, rsp);
			if (rsp.prdata[0] && rd_cnt < 100) begin
				apb_xfer(1'b0, `FT_REG_DATA, 32'h0, rsp);
				c2h_got.push_back(rsp);
				rd_cnt++;
			end
		end
		wait_drained();

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
